/* hdl/exu_alu.sv */
// execute ALU with operand select, word cutting, arithmetic, shifts, mul and div
`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_pkg::*; (
  input  wire logic [XLEN-1:0] i_rs1,
  input  wire logic [XLEN-1:0] i_rs2,
  input  wire logic [XLEN-1:0] i_imm,
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic            i_a_pc,
  input  wire bsrc_t           i_b_src,
  input  wire alu_op_t         i_alu_op,
  input  wire logic            i_word,
  output logic [XLEN-1:0]      o_result,
  output logic                 o_zero,
  output logic                 o_less
);

  localparam int NR_BSRC = 3;
  localparam int NR_RES  = 16;

  localparam bsrc_t BSRC_KEYS [NR_BSRC] = '{BSRC_RS2, BSRC_IMM, BSRC_FOUR};

  localparam alu_op_t RES_KEYS [NR_RES] = '{
    ALU_COPY, ALU_ADD,  ALU_SLT, ALU_SLTU,
    ALU_SUB,  ALU_XOR,  ALU_AND, ALU_OR,
    ALU_SLL,  ALU_SRL,  ALU_SRA, ALU_MUL,
    ALU_DIV,  ALU_DIVU, ALU_REM, ALU_REMU
  };

  localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};

  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] imm_c;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] b_values [NR_BSRC];

  logic [XLEN-1:0] add_res;
  logic [XLEN-1:0] sub_res;
  logic            carry;
  logic            ovf;
  logic            less_s;
  logic            less_u;

  logic [5:0]      shamt;
  logic [XLEN-1:0] sra_src;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] mul_res;

  logic [XLEN-1:0] dvd_s;
  logic [XLEN-1:0] dvs_s;
  logic            div_zero;
  logic            div_ovf;
  logic [XLEN-1:0] div_res;
  logic [XLEN-1:0] divu_res;
  logic [XLEN-1:0] rem_res;
  logic [XLEN-1:0] remu_res;

  logic [XLEN-1:0] res_values [NR_RES];
  logic [XLEN-1:0] alu_res;

  // word ops see only the low 32 bits
  assign src1  = i_word ? {32'd0, i_rs1[31:0]} : i_rs1;
  assign src2  = i_word ? {32'd0, i_rs2[31:0]} : i_rs2;
  assign imm_c = i_word ? {32'd0, i_imm[31:0]} : i_imm;

  assign src_a    = i_a_pc ? i_pc : src1;
  assign b_values = '{src2, imm_c, 64'd4};

  mux_key #(
    .NR_KEY (NR_BSRC),
    .key_t  (bsrc_t),
    .data_t (logic [XLEN-1:0])
  ) b_mux_i (
    .i_key     (i_b_src),
    .i_keys    (BSRC_KEYS),
    .i_values  (b_values),
    .i_default ({XLEN{1'b0}}),
    .o_out     (src_b)
  );

  assign add_res          = src_a + src_b;
  assign {carry, sub_res} = {1'b0, src_a} + {1'b0, ~src_b} + {{XLEN{1'b0}}, 1'b1};

  // flags from the one subtraction
  assign ovf    = (src_a[XLEN-1] != src_b[XLEN-1]) && (sub_res[XLEN-1] != src_a[XLEN-1]);
  assign less_s = sub_res[XLEN-1] ^ ovf;
  assign less_u = ~carry;
  assign o_zero = ~(|sub_res);
  assign o_less = (i_alu_op == ALU_SLTU) ? less_u : less_s;

  assign shamt   = i_word ? {1'b0, src_b[4:0]} : src_b[5:0];
  assign sra_src = i_word ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign sll_res = src_a << shamt;
  assign srl_res = src_a >> shamt;
  assign sra_res = $signed(sra_src) >>> shamt;
  assign mul_res = src_a * src_b;

  // signed word division works on sign-extended low words
  assign dvd_s = i_word ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign dvs_s = i_word ? {{32{src_b[31]}}, src_b[31:0]} : src_b;

  assign div_zero = (src_b == {XLEN{1'b0}});
  assign div_ovf  = (dvd_s == MIN_VAL) && (dvs_s == {XLEN{1'b1}});

  always_comb begin
    if (div_zero) begin
      div_res  = {XLEN{1'b1}};
      divu_res = {XLEN{1'b1}};
      rem_res  = dvd_s;
      remu_res = src_a;
    end else if (div_ovf) begin
      div_res  = MIN_VAL;
      divu_res = src_a / src_b;
      rem_res  = {XLEN{1'b0}};
      remu_res = src_a % src_b;
    end else begin
      div_res  = $signed(dvd_s) / $signed(dvs_s);
      divu_res = src_a / src_b;
      rem_res  = $signed(dvd_s) % $signed(dvs_s);
      remu_res = src_a % src_b;
    end
  end

  assign res_values = '{
    i_imm,                         add_res,
    {{(XLEN-1){1'b0}}, less_s},    {{(XLEN-1){1'b0}}, less_u},
    sub_res,                       src_a ^ src_b,
    src_a & src_b,                 src_a | src_b,
    sll_res,                       srl_res,
    sra_res,                       mul_res,
    div_res,                       divu_res,
    rem_res,                       remu_res
  };

  mux_key #(
    .NR_KEY (NR_RES),
    .key_t  (alu_op_t),
    .data_t (logic [XLEN-1:0])
  ) res_mux_i (
    .i_key     (i_alu_op),
    .i_keys    (RES_KEYS),
    .i_values  (res_values),
    .i_default ({XLEN{1'b0}}),
    .o_out     (alu_res)
  );

  assign o_result = i_word ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;

endmodule

`default_nettype wire

/* hdl/exu_commit.sv */
// commit block, picks write-back and next pc, registers outputs and status flags
`timescale 1ns/1ps
`default_nettype none

module exu_commit import exu_pkg::*; (
  input  wire logic            clock,
  input  wire logic            i_reset,
  input  wire logic            i_valid,
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic [XLEN-1:0] i_rs1,
  input  wire logic [XLEN-1:0] i_imm,
  input  wire branch_t         i_branch,
  input  wire logic            i_mem_to_reg,
  input  wire alu_op_t         i_alu_op,
  input  wire logic [XLEN-1:0] i_result,
  input  wire logic [XLEN-1:0] i_load_data,
  input  wire logic            i_zero,
  input  wire logic            i_less,
  output logic                 o_valid,
  output logic [XLEN-1:0]      o_alu_result,
  output logic [XLEN-1:0]      o_next_pc,
  output logic [XLEN-1:0]      o_bus_w,
  output logic                 o_ebreak,
  output logic                 o_abort
);

  localparam int NR_BR = 7;

  localparam branch_t BR_KEYS [NR_BR] = '{
    BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE
  };

  logic            taken_values [NR_BR];
  logic            taken;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] offset;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] bus_w;

  assign taken_values = '{1'b0, 1'b1, 1'b1, i_zero, ~i_zero, i_less, ~i_less};

  mux_key #(
    .NR_KEY (NR_BR),
    .key_t  (branch_t),
    .data_t (logic)
  ) taken_mux_i (
    .i_key     (i_branch),
    .i_keys    (BR_KEYS),
    .i_values  (taken_values),
    .i_default (1'b0),
    .o_out     (taken)
  );

  assign base    = (i_branch == BR_JALR) ? i_rs1 : i_pc;
  assign offset  = taken ? i_imm : 64'd4;
  assign next_pc = base + offset;
  assign bus_w   = i_mem_to_reg ? i_load_data : i_result;

  always_ff @(posedge clock) begin
    if (i_reset) begin
      o_valid      <= 1'b0;
      o_alu_result <= '0;
      o_next_pc    <= '0;
      o_bus_w      <= '0;
      o_ebreak     <= 1'b0;
      o_abort      <= 1'b0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_alu_result <= i_result;
        o_next_pc    <= next_pc;
        o_bus_w      <= bus_w;
        // sticky until reset
        if (i_alu_op == ALU_EBREAK) begin
          o_ebreak <= 1'b1;
        end
        if (i_alu_op == ALU_INVALID) begin
          o_abort <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/exu_load_align.sv */
// load aligner, sign or zero extends read data by the load code
`timescale 1ns/1ps
`default_nettype none

module exu_load_align import exu_pkg::*; (
  input  wire logic [XLEN-1:0] i_rdata,
  input  wire mem_op_t         i_mem_op,
  output logic [XLEN-1:0]      o_load_data
);

  localparam int NR_MEM = 7;

  localparam mem_op_t MEM_KEYS [NR_MEM] = '{
    MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWU, MEM_LD
  };

  logic [XLEN-1:0] ext_values [NR_MEM];

  // lwu zero extends like the other unsigned loads
  assign ext_values = '{
    {{56{i_rdata[7]}}, i_rdata[7:0]},
    {56'd0, i_rdata[7:0]},
    {{48{i_rdata[15]}}, i_rdata[15:0]},
    {48'd0, i_rdata[15:0]},
    {{32{i_rdata[31]}}, i_rdata[31:0]},
    {32'd0, i_rdata[31:0]},
    i_rdata
  };

  mux_key #(
    .NR_KEY (NR_MEM),
    .key_t  (mem_op_t),
    .data_t (logic [XLEN-1:0])
  ) ext_mux_i (
    .i_key     (i_mem_op),
    .i_keys    (MEM_KEYS),
    .i_values  (ext_values),
    .i_default ({XLEN{1'b0}}),
    .o_out     (o_load_data)
  );

endmodule

`default_nettype wire

/* hdl/exu_pkg.sv */
// execute stage package with data width, ALU, branch, load and operand-B codes
`default_nettype none

package exu_pkg;

  localparam int XLEN = 64;

  // ALU control codes
  typedef logic [4:0] alu_op_t;

  localparam alu_op_t ALU_ADD     = 5'b00000;
  localparam alu_op_t ALU_SLL     = 5'b00001;
  localparam alu_op_t ALU_SLT     = 5'b00010;
  localparam alu_op_t ALU_COPY    = 5'b00011;
  localparam alu_op_t ALU_XOR     = 5'b00100;
  localparam alu_op_t ALU_SRL     = 5'b00101;
  localparam alu_op_t ALU_OR      = 5'b00110;
  localparam alu_op_t ALU_AND     = 5'b00111;
  localparam alu_op_t ALU_SUB     = 5'b01000;
  localparam alu_op_t ALU_SLTU    = 5'b01010;
  localparam alu_op_t ALU_SRA     = 5'b01101;
  localparam alu_op_t ALU_REMU    = 5'b11001;
  localparam alu_op_t ALU_DIVU    = 5'b11010;
  localparam alu_op_t ALU_DIV     = 5'b11011;
  localparam alu_op_t ALU_MUL     = 5'b11100;
  localparam alu_op_t ALU_REM     = 5'b11101;
  localparam alu_op_t ALU_EBREAK  = 5'b11110;
  localparam alu_op_t ALU_INVALID = 5'b11111;

  // next pc codes
  typedef logic [2:0] branch_t;

  localparam branch_t BR_NONE = 3'b000;
  localparam branch_t BR_JAL  = 3'b001;
  localparam branch_t BR_JALR = 3'b010;
  localparam branch_t BR_EQ   = 3'b100;
  localparam branch_t BR_NE   = 3'b101;
  localparam branch_t BR_LT   = 3'b110;
  localparam branch_t BR_GE   = 3'b111;

  // load extension codes
  typedef logic [2:0] mem_op_t;

  localparam mem_op_t MEM_LB  = 3'b000;
  localparam mem_op_t MEM_LBU = 3'b001;
  localparam mem_op_t MEM_LH  = 3'b010;
  localparam mem_op_t MEM_LHU = 3'b011;
  localparam mem_op_t MEM_LW  = 3'b100;
  localparam mem_op_t MEM_LWU = 3'b101;
  localparam mem_op_t MEM_LD  = 3'b110;

  // operand B source
  typedef logic [1:0] bsrc_t;

  localparam bsrc_t BSRC_RS2  = 2'b00;
  localparam bsrc_t BSRC_IMM  = 2'b01;
  localparam bsrc_t BSRC_FOUR = 2'b10;

endpackage

`default_nettype wire

/* hdl/exu_top.sv */
// execute stage top, ALU and load aligner feeding the commit registers
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
  input  wire logic            clock,
  input  wire logic            i_reset,
  input  wire logic            i_valid,
  input  wire logic [XLEN-1:0] i_rs1,
  input  wire logic [XLEN-1:0] i_rs2,
  input  wire logic [XLEN-1:0] i_imm,
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic            i_a_pc,
  input  wire bsrc_t           i_b_src,
  input  wire alu_op_t         i_alu_op,
  input  wire logic            i_word,
  input  wire branch_t         i_branch,
  input  wire mem_op_t         i_mem_op,
  input  wire logic            i_mem_to_reg,
  input  wire logic [XLEN-1:0] i_rdata,
  output logic                 o_valid,
  output logic [XLEN-1:0]      o_alu_result,
  output logic [XLEN-1:0]      o_next_pc,
  output logic [XLEN-1:0]      o_bus_w,
  output logic                 o_ebreak,
  output logic                 o_abort
);

  logic [XLEN-1:0] alu_result;
  logic            alu_zero;
  logic            alu_less;
  logic [XLEN-1:0] load_data;

  exu_alu exu_alu_i (
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .i_imm    (i_imm),
    .i_pc     (i_pc),
    .i_a_pc   (i_a_pc),
    .i_b_src  (i_b_src),
    .i_alu_op (i_alu_op),
    .i_word   (i_word),
    .o_result (alu_result),
    .o_zero   (alu_zero),
    .o_less   (alu_less)
  );

  exu_load_align exu_load_align_i (
    .i_rdata     (i_rdata),
    .i_mem_op    (i_mem_op),
    .o_load_data (load_data)
  );

  exu_commit exu_commit_i (
    .clock        (clock),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_pc         (i_pc),
    .i_rs1        (i_rs1),
    .i_imm        (i_imm),
    .i_branch     (i_branch),
    .i_mem_to_reg (i_mem_to_reg),
    .i_alu_op     (i_alu_op),
    .i_result     (alu_result),
    .i_load_data  (load_data),
    .i_zero       (alu_zero),
    .i_less       (alu_less),
    .o_valid      (o_valid),
    .o_alu_result (o_alu_result),
    .o_next_pc    (o_next_pc),
    .o_bus_w      (o_bus_w),
    .o_ebreak     (o_ebreak),
    .o_abort      (o_abort)
  );

endmodule

`default_nettype wire

/* hdl/mux_key.sv */
// keyed lookup multiplexer, returns the payload of the matching key or a default
`timescale 1ns/1ps
`default_nettype none

module mux_key #(
  parameter int  NR_KEY = 2,
  parameter type key_t  = logic,
  parameter type data_t = logic
) (
  input  key_t  i_key,
  input  key_t  i_keys    [NR_KEY],
  input  data_t i_values  [NR_KEY],
  input  data_t i_default,
  output data_t o_out
);

  always_comb begin
    o_out = i_default;
    // later entries win on duplicate keys
    for (int i = 0; i < NR_KEY; i++) begin
      if (i_key == i_keys[i]) begin
        o_out = i_values[i];
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the execute stage testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module exu_tb -f sim.f --Mdir obj_dir -o exu_sim &&
  ./obj_dir/exu_sim > sim.log 2>&1 ||
  echo "build or run stopped early"

cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

/* sim.f */
+incdir+verif
hdl/exu_pkg.sv
hdl/mux_key.sv
hdl/exu_alu.sv
hdl/exu_load_align.sv
hdl/exu_commit.sv
hdl/exu_top.sv
verif/exu_tb.sv

/* verif/exu_ref.svh */
// reference model of the execute stage: operands, ALU, load extension, next pc, LFSR
`ifndef EXU_REF_SVH
`define EXU_REF_SVH

function automatic logic [63:0] sext32(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

// rs1 is cut to its low word for word ops, the pc never is
function automatic logic [63:0] operand_a(input logic [63:0] rs1, input logic [63:0] pc,
                                          input logic a_pc, input logic word);
  if (a_pc) begin
    return pc;
  end
  return word ? {32'd0, rs1[31:0]} : rs1;
endfunction

function automatic logic [63:0] operand_b(input logic [63:0] rs2, input logic [63:0] imm,
                                          input bsrc_t b_src, input logic word);
  case (b_src)
    BSRC_RS2:  return word ? {32'd0, rs2[31:0]} : rs2;
    BSRC_IMM:  return word ? {32'd0, imm[31:0]} : imm;
    BSRC_FOUR: return 64'd4;
    default:   return 64'd0;
  endcase
endfunction

// RISC-V rules for zero divisors and signed overflow
function automatic logic [63:0] div_ref(input alu_op_t op, input logic [63:0] a,
                                        input logic [63:0] b);
  logic [63:0] min_val;
  min_val = 64'h8000_0000_0000_0000;
  if (b == 64'd0) begin
    if (op == ALU_DIV || op == ALU_DIVU) begin
      return 64'hffff_ffff_ffff_ffff;
    end
    return a;
  end
  if (op == ALU_DIVU) begin
    return a / b;
  end
  if (op == ALU_REMU) begin
    return a % b;
  end
  if (a == min_val && b == 64'hffff_ffff_ffff_ffff) begin
    return (op == ALU_DIV) ? min_val : 64'd0;
  end
  if (op == ALU_DIV) begin
    return $signed(a) / $signed(b);
  end
  return $signed(a) % $signed(b);
endfunction

function automatic logic [63:0] alu_full(input alu_op_t op, input logic [63:0] a,
                                         input logic [63:0] b, input logic [63:0] imm);
  case (op)
    ALU_COPY: return imm;
    ALU_ADD:  return a + b;
    ALU_SUB:  return a - b;
    ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
    ALU_XOR:  return a ^ b;
    ALU_AND:  return a & b;
    ALU_OR:   return a | b;
    ALU_SLL:  return a << b[5:0];
    ALU_SRL:  return a >> b[5:0];
    ALU_SRA:  return $signed(a) >>> b[5:0];
    ALU_MUL:  return a * b;
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: return div_ref(op, a, b);
    default:  return 64'd0;
  endcase
endfunction

// word ops work on the low words and sign-extend bit 31
function automatic logic [63:0] alu_ref(input alu_op_t op, input logic [63:0] a,
                                        input logic [63:0] b, input logic [63:0] imm,
                                        input logic word);
  logic [63:0] w;
  if (!word) begin
    return alu_full(op, a, b, imm);
  end
  case (op)
    ALU_SLL:            w = {32'd0, a[31:0] << b[4:0]};
    ALU_SRL:            w = {32'd0, a[31:0] >> b[4:0]};
    ALU_SRA:            w = {32'd0, $signed(a[31:0]) >>> b[4:0]};
    ALU_DIV, ALU_REM:   w = div_ref(op, sext32(a[31:0]), sext32(b[31:0]));
    ALU_DIVU, ALU_REMU: w = div_ref(op, {32'd0, a[31:0]}, {32'd0, b[31:0]});
    default:            w = alu_full(op, a, b, imm);
  endcase
  return sext32(w[31:0]);
endfunction

function automatic logic [63:0] next_pc_ref(input branch_t br, input alu_op_t op,
                                            input logic [63:0] a, input logic [63:0] b,
                                            input logic [63:0] pc, input logic [63:0] rs1,
                                            input logic [63:0] imm);
  logic eq;
  logic lt;
  logic take;
  eq = (a == b);
  lt = (op == ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));
  case (br)
    BR_JAL, BR_JALR: take = 1'b1;
    BR_EQ:           take = eq;
    BR_NE:           take = !eq;
    BR_LT:           take = lt;
    BR_GE:           take = !lt;
    default:         take = 1'b0;
  endcase
  if (br == BR_JALR) begin
    return rs1 + imm;
  end
  return pc + (take ? imm : 64'd4);
endfunction

function automatic logic [63:0] load_ref(input mem_op_t m, input logic [63:0] d);
  case (m)
    MEM_LB:  return {{56{d[7]}}, d[7:0]};
    MEM_LBU: return {56'd0, d[7:0]};
    MEM_LH:  return {{48{d[15]}}, d[15:0]};
    MEM_LHU: return {48'd0, d[15:0]};
    MEM_LW:  return sext32(d[31:0]);
    MEM_LWU: return {32'd0, d[31:0]};
    MEM_LD:  return d;
    default: return 64'd0;
  endcase
endfunction

// fibonacci taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

/* verif/exu_tb.sv */
// testbench for the execute stage, random and directed ops against a reference model
`timescale 1ns/1ps
`default_nettype none

module exu_tb import exu_pkg::*; ();

  typedef struct packed {
    logic [63:0] result;
    logic [63:0] next_pc;
    logic [63:0] bus_w;
    logic        ebreak;
    logic        abort;
    logic [31:0] stamp;
  } exp_t;

  logic            clock;
  logic            i_reset;
  logic            i_valid;
  logic [XLEN-1:0] i_rs1;
  logic [XLEN-1:0] i_rs2;
  logic [XLEN-1:0] i_imm;
  logic [XLEN-1:0] i_pc;
  logic            i_a_pc;
  bsrc_t           i_b_src;
  alu_op_t         i_alu_op;
  logic            i_word;
  branch_t         i_branch;
  mem_op_t         i_mem_op;
  logic            i_mem_to_reg;
  logic [XLEN-1:0] i_rdata;
  logic            o_valid;
  logic [XLEN-1:0] o_alu_result;
  logic [XLEN-1:0] o_next_pc;
  logic [XLEN-1:0] o_bus_w;
  logic            o_ebreak;
  logic            o_abort;

  exp_t        exp_q [$];
  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;
  logic        exp_ebreak = 1'b0;
  logic        exp_abort = 1'b0;
  logic [31:0] lfsr_state = 32'h2b39;
  logic [63:0] base_pc = 64'h0000_0000_8000_1000;

  `include "exu_ref.svh"

  exu_top exu_top_i (
    .clock        (clock),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_imm        (i_imm),
    .i_pc         (i_pc),
    .i_a_pc       (i_a_pc),
    .i_b_src      (i_b_src),
    .i_alu_op     (i_alu_op),
    .i_word       (i_word),
    .i_branch     (i_branch),
    .i_mem_op     (i_mem_op),
    .i_mem_to_reg (i_mem_to_reg),
    .i_rdata      (i_rdata),
    .o_valid      (o_valid),
    .o_alu_result (o_alu_result),
    .o_next_pc    (o_next_pc),
    .o_bus_w      (o_bus_w),
    .o_ebreak     (o_ebreak),
    .o_abort      (o_abort)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  // one output bit per lfsr step
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = 64'd0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic drive_op(input alu_op_t op, input logic word, input logic a_pc,
                          input bsrc_t b_src, input branch_t br, input logic mem_to_reg,
                          input mem_op_t mem_op, input logic [63:0] rs1,
                          input logic [63:0] rs2, input logic [63:0] imm,
                          input logic [63:0] pc, input logic [63:0] rdata);
    logic [63:0] a;
    logic [63:0] b;
    exp_t        e;
    @(posedge clock);
    i_valid      <= 1'b1;
    i_alu_op     <= op;
    i_word       <= word;
    i_a_pc       <= a_pc;
    i_b_src      <= b_src;
    i_branch     <= br;
    i_mem_to_reg <= mem_to_reg;
    i_mem_op     <= mem_op;
    i_rs1        <= rs1;
    i_rs2        <= rs2;
    i_imm        <= imm;
    i_pc         <= pc;
    i_rdata      <= rdata;
    a = operand_a(rs1, pc, a_pc, word);
    b = operand_b(rs2, imm, b_src, word);
    if (op == ALU_EBREAK) begin
      exp_ebreak = 1'b1;
    end
    if (op == ALU_INVALID) begin
      exp_abort = 1'b1;
    end
    e.result  = alu_ref(op, a, b, imm, word);
    e.next_pc = next_pc_ref(br, op, a, b, pc, rs1, imm);
    e.bus_w   = mem_to_reg ? load_ref(mem_op, rdata) : e.result;
    e.ebreak  = exp_ebreak;
    e.abort   = exp_abort;
    e.stamp   = cycle;
    exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      i_valid <= 1'b0;
    end
  endtask

  task automatic hold_reset();
    @(posedge clock);
    i_reset <= 1'b1;
    i_valid <= 1'b0;
    repeat (16) @(posedge clock);
    i_reset <= 1'b0;
    exp_ebreak = 1'b0;
    exp_abort  = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(negedge clock);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout while waiting for %0d outstanding results", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic check_cleared();
    @(negedge clock);
    check("o_valid", 64'(o_valid), 64'd0);
    check("o_ebreak", 64'(o_ebreak), 64'd0);
    check("o_abort", 64'(o_abort), 64'd0);
    check("o_alu_result", o_alu_result, 64'd0);
    check("o_next_pc", o_next_pc, 64'd0);
    check("o_bus_w", o_bus_w, 64'd0);
  endtask

  task automatic random_op();
    alu_op_t     ops [16];
    logic [63:0] r;
    bsrc_t       b_src;
    branch_t     br;
    logic [63:0] rs2;
    ops = '{ALU_COPY, ALU_ADD, ALU_SLT, ALU_SLTU, ALU_SUB, ALU_XOR, ALU_AND, ALU_OR,
            ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    r = take_bits(2);
    b_src = (r[1:0] == 2'b11) ? BSRC_RS2 : bsrc_t'(r[1:0]);
    r = take_bits(3);
    br = (r[2:0] == 3'b011) ? BR_NONE : branch_t'(r[2:0]);
    // small divisors and shift amounts now and then
    r = take_bits(1);
    if (r[0]) begin
      rs2 = take_bits(64);
    end else begin
      rs2 = take_bits(6);
    end
    r = take_bits(5);
    drive_op(ops[r[4:1]], 1'b0, r[0], b_src, br, 1'b0, MEM_LD, take_bits(64), rs2,
             take_bits(64), take_bits(64), take_bits(64));
  endtask

  task automatic run_word_ops();
    alu_op_t     ops [6];
    logic [63:0] a_vals [3];
    logic [63:0] b_vals [3];
    ops    = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL};
    a_vals = '{64'hdead_beef_8000_0001, 64'h0123_4567_7fff_ffff, 64'hffff_ffff_ffff_fff0};
    b_vals = '{64'h0000_0000_0000_0021, 64'hffff_ffff_0000_001f, 64'h5555_5555_8000_0003};
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 3; j++) begin
        drive_op(ops[i], 1'b1, 1'b0, BSRC_RS2, BR_NONE, 1'b0, MEM_LD, a_vals[j], b_vals[j],
                 64'd0, base_pc, 64'd0);
        drive_op(ops[i], 1'b1, 1'b0, BSRC_IMM, BR_NONE, 1'b0, MEM_LD, a_vals[j], 64'd0,
                 b_vals[j], base_pc, 64'd0);
      end
    end
  endtask

  task automatic run_div_corners();
    alu_op_t     ops [4];
    logic [63:0] a_vals [5];
    logic [63:0] b_vals [5];
    ops    = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    a_vals = '{64'h1234_5678_9abc_def0, 64'h8000_0000_0000_0000, 64'hffff_ffff_8000_0000,
               64'h8000_0000_0000_0005, 64'hffff_ffff_ffff_fff9};
    b_vals = '{64'd0, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 64'd3, 64'd2};
    for (int w = 0; w < 2; w++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 5; j++) begin
          drive_op(ops[i], w[0], 1'b0, BSRC_RS2, BR_NONE, 1'b0, MEM_LD, a_vals[j], b_vals[j],
                   64'd0, base_pc, 64'd0);
        end
      end
    end
  endtask

  task automatic run_branches();
    branch_t     codes [7];
    logic [63:0] a_vals [4];
    logic [63:0] b_vals [4];
    logic [63:0] imm;
    codes  = '{BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE};
    // equal, less both ways, less signed only, greater
    a_vals = '{64'd5, 64'd1, 64'hffff_ffff_ffff_ffff, 64'd2};
    b_vals = '{64'd5, 64'd2, 64'd1, 64'd1};
    for (int c = 0; c < 7; c++) begin
      for (int j = 0; j < 4; j++) begin
        imm = j[0] ? 64'hffff_ffff_ffff_ffe0 : 64'h0000_0000_0000_0120;
        drive_op(ALU_SUB, 1'b0, 1'b0, BSRC_RS2, codes[c], 1'b0, MEM_LD, a_vals[j], b_vals[j],
                 imm, base_pc, 64'd0);
        drive_op(ALU_SLTU, 1'b0, 1'b0, BSRC_RS2, codes[c], 1'b0, MEM_LD, a_vals[j], b_vals[j],
                 imm, base_pc, 64'd0);
      end
    end
  endtask

  task automatic run_loads_and_status();
    logic [63:0] data [2];
    data = '{64'h8bad_f00d_c0de_f0a5, 64'h7654_3210_0123_4567};
    for (int j = 0; j < 2; j++) begin
      for (int m = 0; m < 8; m++) begin
        drive_op(ALU_ADD, 1'b0, 1'b0, BSRC_IMM, BR_NONE, 1'b1, mem_op_t'(m), 64'h100, 64'd0,
                 64'd8, base_pc, data[j]);
      end
    end
    drive_op(ALU_EBREAK, 1'b0, 1'b0, BSRC_RS2, BR_NONE, 1'b0, MEM_LD, 64'd1, 64'd2, 64'd0,
             base_pc, 64'd0);
    repeat (3) begin
      drive_op(ALU_ADD, 1'b0, 1'b0, BSRC_RS2, BR_NONE, 1'b0, MEM_LD, 64'd7, 64'd9, 64'd0,
               base_pc, 64'd0);
    end
    drive_op(ALU_INVALID, 1'b0, 1'b0, BSRC_RS2, BR_NONE, 1'b0, MEM_LD, 64'd3, 64'd4, 64'd0,
             base_pc, 64'd0);
    repeat (2) begin
      drive_op(ALU_XOR, 1'b0, 1'b0, BSRC_RS2, BR_JAL, 1'b0, MEM_LD, 64'd5, 64'd6, 64'h40,
               base_pc, 64'd0);
    end
    idle(4);
    wait_drain();
    @(negedge clock);
    check("o_ebreak", 64'(o_ebreak), 64'd1);
    check("o_abort", 64'(o_abort), 64'd1);
  endtask

  // compare process, outputs sampled mid cycle
  always @(negedge clock) begin
    exp_t e;
    if (!i_reset) begin
      if (o_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("o_valid came with no op outstanding at %0t", $time);
        end else begin
          e = exp_q.pop_front();
          check("o_alu_result", o_alu_result, e.result);
          check("o_next_pc", o_next_pc, e.next_pc);
          check("o_bus_w", o_bus_w, e.bus_w);
          check("o_ebreak", 64'(o_ebreak), 64'(e.ebreak));
          check("o_abort", 64'(o_abort), 64'(e.abort));
        end
      end else if (exp_q.size() != 0 && cycle - int'(exp_q[0].stamp) >= 2) begin
        errors++;
        $display("no o_valid for the op issued in cycle %0d", exp_q[0].stamp);
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin
    i_reset      = 1'b1;
    i_valid      = 1'b0;
    i_rs1        = '0;
    i_rs2        = '0;
    i_imm        = '0;
    i_pc         = '0;
    i_a_pc       = 1'b0;
    i_b_src      = BSRC_RS2;
    i_alu_op     = ALU_ADD;
    i_word       = 1'b0;
    i_branch     = BR_NONE;
    i_mem_op     = MEM_LD;
    i_mem_to_reg = 1'b0;
    i_rdata      = '0;
    hold_reset();
    check_cleared();
    idle(6);
    check_cleared();
    for (int k = 0; k < 400; k++) begin
      random_op();
    end
    idle(1);
    wait_drain();
    run_word_ops();
    idle(1);
    wait_drain();
    run_div_corners();
    idle(1);
    wait_drain();
    run_branches();
    idle(1);
    wait_drain();
    run_loads_and_status();
    // flags must drop with the next reset
    hold_reset();
    check_cleared();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
